/* logic/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    // Bus data word
    typedef logic [31:0] word_t;

    // Upper nibble picks the peripheral, lower nibble the register
    typedef logic [7:0] addr_t;

    typedef logic [3:0] reg_addr_t;

    // One bit per byte lane
    typedef logic [3:0] mask_t;

    typedef logic [3:0] periph_t;

    localparam periph_t PERIPH_DISPLAY = 4'd0;
    localparam periph_t PERIPH_GPIO    = 4'd1;

endpackage

`default_nettype wire

/* logic/display_pkg.sv */
`default_nettype none

package display_pkg;

    localparam bus_pkg::reg_addr_t REG_CONTROL = 4'd0;
    localparam bus_pkg::reg_addr_t REG_DATA    = 4'd1;

    localparam int unsigned DIGITS = 8;

    // Active low, bit 7 is the decimal point, bits 6..0 are g..a
    typedef logic [7:0] seg_pattern_t;

    function automatic seg_pattern_t hex_segments(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 8'b1100_0000;
            4'h1: return 8'b1111_1001;
            4'h2: return 8'b1010_0100;
            4'h3: return 8'b1011_0000;
            4'h4: return 8'b1001_1001;
            4'h5: return 8'b1001_0010;
            4'h6: return 8'b1000_0010;
            4'h7: return 8'b1111_1000;
            4'h8: return 8'b1000_0000;
            4'h9: return 8'b1001_1000;
            4'hA: return 8'b1000_1000;
            4'hB: return 8'b1000_0011;
            4'hC: return 8'b1100_0110;
            4'hD: return 8'b1010_0001;
            4'hE: return 8'b1000_0110;
            default: return 8'b1000_1110;
        endcase
    endfunction

endpackage

`default_nettype wire

/* logic/seg_display.sv */
`timescale 1ns/1ps
`default_nettype none

module seg_display #(
    parameter int unsigned CLK_DIVISOR = 32768
) (
    input  wire logic               clk_i,
    input  wire logic               reset_i,
    input  wire logic               chip_select_i,
    input  wire bus_pkg::reg_addr_t addr_i,
    input  wire logic               read_enable_i,
    input  wire bus_pkg::word_t     write_data_i,
    input  wire bus_pkg::mask_t     write_mask_i,
    output bus_pkg::word_t          read_data_o,
    output logic [7:0]              dsp_anode_o,
    output logic [7:0]              dsp_cathode_o
);

    localparam int unsigned COUNTER_WIDTH = $clog2(CLK_DIVISOR) + 4;
    localparam int unsigned DIGIT_BITS    = $clog2(display_pkg::DIGITS);

    logic                     enabled_r;
    bus_pkg::word_t           value_r;
    logic [COUNTER_WIDTH-1:0] counter_r;
    logic [DIGIT_BITS-1:0]    digit_w;
    logic                     lit_w;
    logic [3:0]               nibble_w;
    logic                     read_w;
    logic                     write_w;

    assign read_w  = chip_select_i && read_enable_i;
    assign write_w = chip_select_i && !read_enable_i;

    // Read data is registered and held until the next read
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            read_data_o <= '0;
        end else if (read_w) begin
            case (addr_i)
                display_pkg::REG_CONTROL: read_data_o <= bus_pkg::word_t'(enabled_r);
                display_pkg::REG_DATA:    read_data_o <= value_r;
                default:                  read_data_o <= '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            enabled_r <= 1'b0;
        end else if (write_w && addr_i == display_pkg::REG_CONTROL && write_mask_i[0]) begin
            enabled_r <= write_data_i[0];
        end
    end

    // Byte-lane merge into the value
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            value_r <= '0;
        end else if (write_w && addr_i == display_pkg::REG_DATA) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (write_mask_i[lane]) begin
                    value_r[lane*8 +: 8] <= write_data_i[lane*8 +: 8];
                end
            end
        end
    end

    // Scan counter, parked at zero while disabled
    always_ff @(posedge clk_i) begin
        if (reset_i || !enabled_r) begin
            counter_r <= '0;
        end else begin
            counter_r <= counter_r + 1'b1;
        end
    end

    // Top bits pick the digit, next bit is the lit half
    assign digit_w  = counter_r[COUNTER_WIDTH-1 -: DIGIT_BITS];
    assign lit_w    = enabled_r && counter_r[COUNTER_WIDTH-1-DIGIT_BITS];
    assign nibble_w = value_r[digit_w*4 +: 4];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dsp_anode_o   <= '1;
            dsp_cathode_o <= '1;
        end else if (lit_w) begin
            dsp_anode_o   <= ~(8'b1 << digit_w);
            dsp_cathode_o <= display_pkg::hex_segments(nibble_w);
        end else begin
            // Dark half blanks the digit to avoid ghosting
            dsp_anode_o   <= '1;
            dsp_cathode_o <= '1;
        end
    end

endmodule

`default_nettype wire

/* logic/gpio_port.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_port (
    input  wire logic               clk_i,
    input  wire logic               reset_i,
    input  wire logic               chip_select_i,
    input  wire bus_pkg::reg_addr_t addr_i,
    input  wire logic               read_enable_i,
    input  wire bus_pkg::word_t     write_data_i,
    input  wire bus_pkg::mask_t     write_mask_i,
    input  wire logic [15:0]        switch_i,
    output bus_pkg::word_t          read_data_o,
    output logic [15:0]             led_o
);

    localparam bus_pkg::reg_addr_t REG_LEDS     = 4'd0;
    localparam bus_pkg::reg_addr_t REG_SWITCHES = 4'd1;

    logic [15:0] switch_meta_r;
    logic [15:0] switch_sync_r;
    logic        write_w;

    assign write_w = chip_select_i && !read_enable_i && addr_i == REG_LEDS;

    // LEDs only use lanes 0 and 1
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            led_o <= '0;
        end else if (write_w) begin
            if (write_mask_i[0]) led_o[7:0]  <= write_data_i[7:0];
            if (write_mask_i[1]) led_o[15:8] <= write_data_i[15:8];
        end
    end

    // Two-flop synchronizer for the asynchronous switches
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            switch_meta_r <= '0;
            switch_sync_r <= '0;
        end else begin
            switch_meta_r <= switch_i;
            switch_sync_r <= switch_meta_r;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            read_data_o <= '0;
        end else if (chip_select_i && read_enable_i) begin
            case (addr_i)
                REG_LEDS:     read_data_o <= bus_pkg::word_t'(led_o);
                REG_SWITCHES: read_data_o <= bus_pkg::word_t'(switch_sync_r);
                default:      read_data_o <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/bus_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
    input  wire logic               clk_i,
    input  wire logic               reset_i,
    input  wire logic               cs_i,
    input  wire bus_pkg::addr_t     addr_i,
    input  wire bus_pkg::word_t     disp_read_data_i,
    input  wire bus_pkg::word_t     gpio_read_data_i,
    output wire logic               disp_cs_o,
    output wire logic               gpio_cs_o,
    output wire bus_pkg::reg_addr_t reg_addr_o,
    output wire bus_pkg::word_t     read_data_o
);

    bus_pkg::periph_t periph_w;
    logic             disp_sel_r;
    logic             gpio_sel_r;

    assign periph_w   = addr_i[7:4];
    assign reg_addr_o = addr_i[3:0];

    // Unmapped nibbles leave both selects low
    assign disp_cs_o = cs_i && (periph_w == bus_pkg::PERIPH_DISPLAY);
    assign gpio_cs_o = cs_i && (periph_w == bus_pkg::PERIPH_GPIO);

    // Remember the target of the access so the registered
    // peripheral data lines up one cycle later
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            disp_sel_r <= 1'b0;
            gpio_sel_r <= 1'b0;
        end else if (cs_i) begin
            disp_sel_r <= disp_cs_o;
            gpio_sel_r <= gpio_cs_o;
        end
    end

    assign read_data_o = disp_sel_r ? disp_read_data_i :
                         gpio_sel_r ? gpio_read_data_i :
                         '0;

endmodule

`default_nettype wire

/* logic/periph_top.sv */
`timescale 1ns/1ps
`default_nettype none

module periph_top #(
    parameter int unsigned CLK_DIVISOR = 32768
) (
    input  wire logic           clk_i,
    input  wire logic           reset_i,
    input  wire logic           cs_i,
    input  wire bus_pkg::addr_t addr_i,
    input  wire logic           read_enable_i,
    input  wire bus_pkg::word_t write_data_i,
    input  wire bus_pkg::mask_t write_mask_i,
    input  wire logic [15:0]    switch_i,
    output wire bus_pkg::word_t read_data_o,
    output wire logic [7:0]     dsp_anode_o,
    output wire logic [7:0]     dsp_cathode_o,
    output wire logic [15:0]    led_o
);

    wire logic               disp_cs;
    wire logic               gpio_cs;
    wire bus_pkg::reg_addr_t reg_addr;
    wire bus_pkg::word_t     disp_read_data;
    wire bus_pkg::word_t     gpio_read_data;

    bus_decoder u_bus_decoder (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .cs_i             (cs_i),
        .addr_i           (addr_i),
        .disp_read_data_i (disp_read_data),
        .gpio_read_data_i (gpio_read_data),
        .disp_cs_o        (disp_cs),
        .gpio_cs_o        (gpio_cs),
        .reg_addr_o       (reg_addr),
        .read_data_o      (read_data_o)
    );

    seg_display #(
        .CLK_DIVISOR (CLK_DIVISOR)
    ) u_seg_display (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .chip_select_i (disp_cs),
        .addr_i        (reg_addr),
        .read_enable_i (read_enable_i),
        .write_data_i  (write_data_i),
        .write_mask_i  (write_mask_i),
        .read_data_o   (disp_read_data),
        .dsp_anode_o   (dsp_anode_o),
        .dsp_cathode_o (dsp_cathode_o)
    );

    gpio_port u_gpio_port (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .chip_select_i (gpio_cs),
        .addr_i        (reg_addr),
        .read_enable_i (read_enable_i),
        .write_data_i  (write_data_i),
        .write_mask_i  (write_mask_i),
        .switch_i      (switch_i),
        .read_data_o   (gpio_read_data),
        .led_o         (led_o)
    );

endmodule

`default_nettype wire

/* test/periph_props.sv */
`timescale 1ns/1ps
`default_nettype none

module periph_props (
    input wire logic       clk_i,
    input wire logic       reset_i,
    input wire logic       enabled_i,
    input wire logic [7:0] anode_i,
    input wire logic [7:0] cathode_i
);

    // At most one digit driven at a time
    anode_single: assert property (@(posedge clk_i) disable iff (reset_i)
        anode_i == 8'hff || $onehot(~anode_i))
        else $error("more than one anode active");

    cathode_dark: assert property (@(posedge clk_i) disable iff (reset_i)
        anode_i == 8'hff |-> cathode_i == 8'hff)
        else $error("cathode lit with no anode active");

    disabled_dark: assert property (@(posedge clk_i) disable iff (reset_i)
        !enabled_i |=> anode_i == 8'hff && cathode_i == 8'hff)
        else $error("display outputs active while disabled");

endmodule

bind seg_display periph_props u_periph_props (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .enabled_i (enabled_r),
    .anode_i   (dsp_anode_o),
    .cathode_i (dsp_cathode_o)
);

`default_nettype wire

/* test/periph_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module periph_tb;

    localparam int unsigned    RESET_CYCLES = 10;
    localparam bus_pkg::addr_t DATA_ADDR    = {bus_pkg::PERIPH_DISPLAY, display_pkg::REG_DATA};
    localparam bus_pkg::addr_t LED_ADDR     = {bus_pkg::PERIPH_GPIO, 4'd0};

    // Lit segments g..a for the glyphs 0 to F
    localparam logic [6:0] GLYPHS [16] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
        7'h7f, 7'h67, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
    };

    logic           clk;
    logic           reset;
    logic           cs;
    bus_pkg::addr_t addr;
    logic           read_enable;
    bus_pkg::word_t write_data;
    bus_pkg::mask_t write_mask;
    logic [15:0]    switches;
    bus_pkg::word_t read_data;
    logic [7:0]     anode;
    logic [7:0]     cathode;
    logic [15:0]    leds;
    bus_pkg::word_t value_model;
    logic [15:0]    led_model;

    periph_top #(
        .CLK_DIVISOR (4)
    ) u_periph_top (
        .clk_i         (clk),
        .reset_i       (reset),
        .cs_i          (cs),
        .addr_i        (addr),
        .read_enable_i (read_enable),
        .write_data_i  (write_data),
        .write_mask_i  (write_mask),
        .switch_i      (switches),
        .read_data_o   (read_data),
        .dsp_anode_o   (anode),
        .dsp_cathode_o (cathode),
        .led_o         (leds)
    );

    always #10 clk = ~clk;

    // Active low, decimal point kept dark
    function automatic display_pkg::seg_pattern_t expected_glyph(input logic [3:0] nibble);
        return ~{1'b0, GLYPHS[nibble]};
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic value_error(input string name, input bus_pkg::word_t expected,
                               input bus_pkg::word_t actual);
        abort_run($sformatf("Error at %0d ns: %s expected %h, got %h",
                            $time, name, expected, actual));
    endtask

    task automatic check_word(input string name, input bus_pkg::word_t expected,
                              input bus_pkg::word_t actual);
        if (actual !== expected) begin
            value_error(name, expected, actual);
        end
    endtask

    task automatic check_anode(input logic [7:0] expected, input logic [7:0] actual);
        if (actual !== expected) begin
            value_error("dsp_anode_o", bus_pkg::word_t'(expected), bus_pkg::word_t'(actual));
        end
    endtask

    task automatic check_cathode(input display_pkg::seg_pattern_t expected,
                                 input display_pkg::seg_pattern_t actual);
        if (actual !== expected) begin
            value_error("dsp_cathode_o", bus_pkg::word_t'(expected), bus_pkg::word_t'(actual));
        end
    endtask

    task automatic check_leds(input logic [15:0] expected, input logic [15:0] actual);
        if (actual !== expected) begin
            value_error("led_o", bus_pkg::word_t'(expected), bus_pkg::word_t'(actual));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic bus_write(input bus_pkg::addr_t a, input bus_pkg::mask_t m,
                             input bus_pkg::word_t d);
        cs          = 1'b1;
        read_enable = 1'b0;
        addr        = a;
        write_mask  = m;
        write_data  = d;
        next_cycle();
        cs         = 1'b0;
        write_mask = '0;
        for (int lane = 0; lane < 4; lane++) begin
            if (a == DATA_ADDR && m[lane]) value_model[lane*8 +: 8] = d[lane*8 +: 8];
        end
        if (a == LED_ADDR && m[0]) led_model[7:0] = d[7:0];
        if (a == LED_ADDR && m[1]) led_model[15:8] = d[15:8];
        check_leds(led_model, leds);
    endtask

    // Fixed one-cycle read latency
    task automatic bus_read(input bus_pkg::addr_t a, input bus_pkg::word_t expected);
        cs          = 1'b1;
        read_enable = 1'b1;
        addr        = a;
        next_cycle();
        cs          = 1'b0;
        read_enable = 1'b0;
        check_word("read_data_o", expected, read_data);
    endtask

    // Two synchronizer stages before a read can see the new value
    task automatic apply_switches(input logic [15:0] value);
        switches = value;
        next_cycle();
        next_cycle();
    endtask

    // Either every digit lights with its modeled glyph, or the display goes dark
    task automatic scan_display(input bus_pkg::word_t budget, input logic lit);
        logic [7:0]  seen;
        logic [7:0]  expected_anode;
        int unsigned cycles;
        int          k;

        seen   = '0;
        cycles = 0;
        while (cycles < budget && (lit ? seen != 8'hff : (anode & cathode) != 8'hff)) begin
            next_cycle();
            cycles++;
            if (lit && anode != 8'hff) begin
                k = 0;
                for (int i = 0; i < 8; i++) begin
                    if (!anode[i]) k = i;
                end
                // Only digit k may be low
                expected_anode    = 8'hff;
                expected_anode[k] = 1'b0;
                check_anode(expected_anode, anode);
                check_cathode(expected_glyph(value_model[k*4 +: 4]), cathode);
                seen[k] = 1'b1;
            end
        end
        if (lit && seen != 8'hff) begin
            abort_run($sformatf("Timeout after %0d cycles, no lit digit appeared at positions %b",
                                budget, ~seen));
        end else if (!lit && (anode & cathode) != 8'hff) begin
            abort_run("Timeout, the display stayed lit after it was disabled");
        end
    endtask

    initial begin
        int             fd;
        int             count;
        string          kind;
        string          rest;
        bus_pkg::addr_t op_addr;
        bus_pkg::mask_t op_mask;
        bus_pkg::word_t op_data;
        bus_pkg::word_t op_expected;

        clk         = 1'b0;
        reset       = 1'b1;
        cs          = 1'b0;
        addr        = '0;
        read_enable = 1'b0;
        write_data  = '0;
        write_mask  = '0;
        switches    = '0;
        value_model = '0;
        led_model   = '0;
        void'($urandom(4623));
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;

        check_word("read_data_o", '0, read_data);
        check_leds('0, leds);
        check_anode(8'hff, anode);
        check_cathode(8'hff, cathode);

        fd = $fopen("test/periph_input.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open test/periph_input.txt");
        end
        count = $fscanf(fd, "%s", kind);
        while (count == 1) begin
            if (kind == "#") begin
                count = $fgets(rest, fd);
            end else begin
                count = $fscanf(fd, "%h %h %h %h", op_addr, op_mask, op_data, op_expected);
                if (count != 4) begin
                    abort_run({"Incomplete line in test/periph_input.txt for ", kind});
                end
                if (kind == "write") begin
                    bus_write(op_addr, op_mask, op_data);
                end else if (kind == "read") begin
                    bus_read(op_addr, op_expected);
                end else if (kind == "switch") begin
                    apply_switches(op_data[15:0]);
                end else if (kind == "scan") begin
                    scan_display(op_data, op_expected[0]);
                end else begin
                    abort_run({"Unknown operation kind ", kind});
                end
                repeat ($urandom % 4) next_cycle();
            end
            count = $fscanf(fd, "%s", kind);
        end
        $fclose(fd);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* test/periph_input.txt */
# kind addr mask data expected, all hex
# scan data is a cycle budget, expected 1 waits for every digit and 0 for a dark display
read   00 0 00000000 00000000
read   01 0 00000000 00000000
write  01 f 12345678 00000000
write  01 1 000000ab 00000000
read   01 0 00000000 123456ab
write  01 6 00cdef00 00000000
write  01 8 9a000000 00000000
write  01 0 ffffffff 00000000
read   01 0 00000000 9acdefab
write  00 e 00000001 00000000
read   00 0 00000000 00000000
write  00 1 ffffffff 00000000
read   00 0 00000000 00000001
scan   00 0 00000100 00000001
write  01 f 0f1e2d3c 00000000
scan   00 0 00000100 00000001
write  00 1 00000000 00000000
scan   00 0 00000010 00000000
write  10 3 0000a5c3 00000000
write  10 2 00007e00 00000000
write  10 c ffff0000 00000000
read   10 0 00000000 00007ec3
switch 00 0 00005aa5 00000000
read   11 0 00000000 00005aa5
write  20 f deadbeef 00000000
write  0f f deadbeef 00000000
write  12 f deadbeef 00000000
read   20 0 00000000 00000000
read   0f 0 00000000 00000000
read   12 0 00000000 00000000
read   01 0 00000000 0f1e2d3c
read   10 0 00000000 00007ec3

/* filelist.f */
logic/bus_pkg.sv
logic/display_pkg.sv
logic/seg_display.sv
logic/gpio_port.sv
logic/bus_decoder.sv
logic/periph_top.sv
test/periph_props.sv
test/periph_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module periph_tb -o periph_sim
./obj_dir/periph_sim 2>&1 | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failures"
